/* Makefile */
# Verilator flow for the multicycle core

VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not from the exit code of the pipe
run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "RESULT: PASS" || (echo "RESULT: FAIL"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim.f */
src/isaPkg.sv
src/busPkg.sv
src/instrMem.sv
src/regFile.sv
src/aluFlags.sv
src/pcCounter.sv
src/coreFsm.sv
src/cpuTop.sv
tests/cpuTop_properties.sv
tests/cpuTb.sv

/* src/aluFlags.sv */
`timescale 1ns/100ps
`default_nettype none

module aluFlags (
  input  logic                         clk,
  input  logic                         rstN,
  input  isaPkg::opcodeT               opcode,
  input  logic [isaPkg::DataWidth-1:0] operandA,
  input  logic [isaPkg::DataWidth-1:0] operandB,
  input  logic [7:0]                   imm8,
  input  isaPkg::condT                 cond,
  input  logic                         update,
  input  logic                         clearFlags,
  output logic [isaPkg::DataWidth-1:0] result,
  output logic                         taken,
  output logic [2:0]                   flags
);
  import isaPkg::*;

  localparam logic [DataWidth-1:0] MaxPos = {1'b0, {(DataWidth-1){1'b1}}};
  localparam logic [DataWidth-1:0] MaxNeg = {1'b1, {(DataWidth-1){1'b0}}};

  logic                 isSub;
  logic [DataWidth-1:0] addB;
  logic [DataWidth-1:0] rawSum;
  logic [DataWidth-1:0] satSum;
  logic                 overflow;

  // SUB is A + ~B + 1 through the same adder
  assign isSub = (opcode == OpSub);
  assign addB = isSub ? ~operandB : operandB;
  assign rawSum = operandA + addB + {{(DataWidth-1){1'b0}}, isSub};

  // Signed overflow when both inputs agree in sign and the sum does not
  assign overflow = (operandA[DataWidth-1] == addB[DataWidth-1]) &&
                    (rawSum[DataWidth-1] != operandA[DataWidth-1]);
  assign satSum = !overflow ? rawSum : (operandA[DataWidth-1] ? MaxNeg : MaxPos);

  always_comb begin
    case (opcode)
      OpAdd, OpSub: result = satSum;
      OpXor:        result = operandA ^ operandB;
      OpLlb:        result = {operandA[DataWidth-1:8], imm8};  // Keep high byte
      OpLhb:        result = {imm8, operandA[7:0]};             // Keep low byte
      default:      result = '0;
    endcase
  end

  // Flag register, written on the Execute edge
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flags <= '0;
    end else if (clearFlags) begin
      flags <= '0;
    end else if (update) begin
      case (opcode)
        OpAdd, OpSub: begin
          flags[FlagN] <= result[DataWidth-1];
          flags[FlagV] <= overflow;
          flags[FlagZ] <= (result == '0);
        end
        OpXor: flags[FlagZ] <= (result == '0);  // N and V left alone
        default: ;
      endcase
    end
  end

  // Branch test against the stored flags
  always_comb begin
    case (cond)
      CondNe:     taken = !flags[FlagZ];
      CondEq:     taken = flags[FlagZ];
      CondGt:     taken = !flags[FlagZ] && !flags[FlagN];
      CondLt:     taken = flags[FlagN];
      CondGte:    taken = flags[FlagZ] || !flags[FlagN];
      CondLte:    taken = flags[FlagN] || flags[FlagZ];
      CondOv:     taken = flags[FlagV];
      CondUncond: taken = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* src/busPkg.sv */
`default_nettype none

package busPkg;

  localparam int ApbAddrWidth = 8;   // Word address

  // Top two address bits
  typedef enum logic [1:0] {
    RegionCtrl   = 2'b00,
    RegionReg    = 2'b01,
    RegionImemLo = 2'b10,
    RegionImemHi = 2'b11
  } regionT;

  localparam logic [ApbAddrWidth-1:0] CtrlAddr = 8'h00;  // W bit0 start, R {halted, busy}
  localparam logic [ApbAddrWidth-1:0] PcAddr = 8'h01;

  typedef enum logic [1:0] {
    StIdle,
    StFetch,
    StExecute,
    StHalted
  } stateT;

endpackage

`default_nettype wire

/* src/coreFsm.sv */
`timescale 1ns/100ps
`default_nettype none

module coreFsm #(
  parameter int ImemDepth = 64
) (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [busPkg::ApbAddrWidth-1:0] paddr,
  input  logic [isaPkg::DataWidth-1:0]    pwdata,
  output logic [isaPkg::DataWidth-1:0]    prdata,
  input  logic [isaPkg::DataWidth-1:0]    instr,
  input  logic [isaPkg::DataWidth-1:0]    rdData1,
  input  logic [isaPkg::DataWidth-1:0]    pc,
  input  logic                            taken,
  output logic                            wrEn,
  output logic [$clog2(ImemDepth)-1:0]    wrIndex,
  output logic                            rdEn,
  output logic [$clog2(ImemDepth)-1:0]    rdIndex,
  output logic [isaPkg::RegAddrWidth-1:0] rdAddr1,
  output logic [isaPkg::RegAddrWidth-1:0] rdAddr2,
  output logic                            regWrEn,
  output logic [isaPkg::RegAddrWidth-1:0] wrAddr,
  output isaPkg::opcodeT                  opcode,
  output isaPkg::condT                    cond,
  output logic [7:0]                      imm8,
  output logic                            update,
  output logic                            clearFlags,
  output logic                            step,
  output logic                            load,
  output logic                            clear,
  output logic [8:0]                      offset,
  output logic                            hlt
);
  import isaPkg::*;
  import busPkg::*;

  localparam int IdxWidth = $clog2(ImemDepth);

  stateT  state;
  stateT  stateNext;
  regionT region;
  logic   apbWrite;
  logic   apbRead;
  logic   busy;
  logic   startReq;
  logic   inExecute;
  logic   writesReg;

  // APB access phase, no wait states
  assign apbWrite = psel && penable && pwrite;
  assign apbRead = psel && penable && !pwrite;
  assign region = regionT'(paddr[ApbAddrWidth-1 -: 2]);

  assign busy = (state == StFetch) || (state == StExecute);
  assign inExecute = (state == StExecute);
  assign hlt = (state == StHalted);
  assign startReq = apbWrite && (paddr == CtrlAddr) && pwdata[0] && !busy;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= StIdle;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      StIdle, StHalted: if (startReq) stateNext = StFetch;
      StFetch:          stateNext = StExecute;
      StExecute:        stateNext = (opcode == OpHlt) ? StHalted : StFetch;
    endcase
  end

  // Instruction fields
  assign opcode = opcodeT'(instr[15:12]);
  assign cond = condT'(instr[11:9]);
  assign imm8 = instr[7:0];
  assign offset = instr[8:0];
  assign wrAddr = instr[11:8];
  assign rdAddr2 = instr[3:0];

  always_comb begin
    if (!busy) begin
      rdAddr1 = paddr[RegAddrWidth-1:0];  // Debug readback
    end else if (instr[15:13] == 3'b101) begin
      rdAddr1 = instr[11:8];              // LHB/LLB modify their destination
    end else begin
      rdAddr1 = instr[7:4];
    end
  end

  always_comb begin
    case (opcode)
      OpAdd, OpSub, OpXor, OpLlb, OpLhb: writesReg = 1'b1;
      default:                           writesReg = 1'b0;  // Dropped opcodes act as no-ops
    endcase
  end

  assign regWrEn = inExecute && writesReg;
  assign update = inExecute;
  assign load = inExecute && (opcode == OpB) && taken;
  assign step = inExecute && !load && (opcode != OpHlt);  // HLT holds the PC
  assign clear = startReq;
  assign clearFlags = startReq;

  // Fetch port, byte PC to word index
  assign rdEn = (state == StFetch);
  assign rdIndex = pc[IdxWidth:1];

  assign wrEn = apbWrite && !busy &&
                ((region == RegionImemLo) || (region == RegionImemHi));
  assign wrIndex = paddr[IdxWidth-1:0];

  always_comb begin
    prdata = '0;
    if (apbRead) begin
      case (region)
        RegionCtrl: begin
          if (paddr == CtrlAddr) begin
            prdata = {{(DataWidth-2){1'b0}}, hlt, busy};
          end else if (paddr == PcAddr) begin
            prdata = pc;
          end
        end
        RegionReg: if (!busy) prdata = rdData1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/cpuTop.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuTop #(
  parameter int ImemDepth = 64
) (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [busPkg::ApbAddrWidth-1:0] paddr,
  input  logic [isaPkg::DataWidth-1:0]    pwdata,
  output logic [isaPkg::DataWidth-1:0]    prdata,
  output logic [isaPkg::DataWidth-1:0]    pc,
  output logic                            hlt
);
  import isaPkg::*;

  localparam int IdxWidth = $clog2(ImemDepth);

  logic [DataWidth-1:0]    instr;
  logic [DataWidth-1:0]    rdData1;
  logic [DataWidth-1:0]    rdData2;
  logic [DataWidth-1:0]    result;
  logic                    taken;
  logic                    memWrEn;
  logic [IdxWidth-1:0]     memWrIndex;
  logic                    memRdEn;
  logic [IdxWidth-1:0]     memRdIndex;
  logic [RegAddrWidth-1:0] rdAddr1;
  logic [RegAddrWidth-1:0] rdAddr2;
  logic                    regWrEn;
  logic [RegAddrWidth-1:0] wrAddr;
  opcodeT                  opcode;
  condT                    cond;
  logic [7:0]              imm8;
  logic                    update;
  logic                    clearFlags;
  logic                    step;
  logic                    load;
  logic                    clear;
  logic [8:0]              offset;

  coreFsm #(
    .ImemDepth(ImemDepth)
  ) i_coreFsm (
    .clk       (clk),
    .rstN      (rstN),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .instr     (instr),
    .rdData1   (rdData1),
    .pc        (pc),
    .taken     (taken),
    .wrEn      (memWrEn),
    .wrIndex   (memWrIndex),
    .rdEn      (memRdEn),
    .rdIndex   (memRdIndex),
    .rdAddr1   (rdAddr1),
    .rdAddr2   (rdAddr2),
    .regWrEn   (regWrEn),
    .wrAddr    (wrAddr),
    .opcode    (opcode),
    .cond      (cond),
    .imm8      (imm8),
    .update    (update),
    .clearFlags(clearFlags),
    .step      (step),
    .load      (load),
    .clear     (clear),
    .offset    (offset),
    .hlt       (hlt)
  );

  instrMem #(
    .ImemDepth(ImemDepth)
  ) i_instrMem (
    .clk    (clk),
    .wrEn   (memWrEn),
    .wrIndex(memWrIndex),
    .wrData (pwdata),       // Program words come straight off the bus
    .rdEn   (memRdEn),
    .rdIndex(memRdIndex),
    .instr  (instr)
  );

  regFile i_regFile (
    .clk    (clk),
    .rstN   (rstN),
    .rdAddr1(rdAddr1),
    .rdAddr2(rdAddr2),
    .rdData1(rdData1),
    .rdData2(rdData2),
    .wrEn   (regWrEn),
    .wrAddr (wrAddr),
    .wrData (result)
  );

  // Flag vector stays internal, only taken leaves the ALU
  aluFlags i_aluFlags (
    .clk       (clk),
    .rstN      (rstN),
    .opcode    (opcode),
    .operandA  (rdData1),
    .operandB  (rdData2),
    .imm8      (imm8),
    .cond      (cond),
    .update    (update),
    .clearFlags(clearFlags),
    .result    (result),
    .taken     (taken),
    .flags     ()
  );

  pcCounter i_pcCounter (
    .clk   (clk),
    .rstN  (rstN),
    .step  (step),
    .load  (load),
    .clear (clear),
    .offset(offset),
    .pc    (pc)
  );

endmodule

`default_nettype wire

/* src/instrMem.sv */
`timescale 1ns/100ps
`default_nettype none

module instrMem #(
  parameter int ImemDepth = 64
) (
  input  logic                         clk,
  input  logic                         wrEn,
  input  logic [$clog2(ImemDepth)-1:0] wrIndex,
  input  logic [isaPkg::DataWidth-1:0] wrData,
  input  logic                         rdEn,
  input  logic [$clog2(ImemDepth)-1:0] rdIndex,
  output logic [isaPkg::DataWidth-1:0] instr
);
  import isaPkg::*;

  logic [DataWidth-1:0] mem [ImemDepth];

  // Loaded over APB while the core is stopped
  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wrIndex] <= wrData;
    end
  end

  // Read in Fetch, the word then stays put through Execute
  always_ff @(posedge clk) begin
    if (rdEn) begin
      instr <= mem[rdIndex];
    end
  end

endmodule

`default_nettype wire

/* src/isaPkg.sv */
`default_nettype none

package isaPkg;

  localparam int DataWidth = 16;   // Data word and instruction
  localparam int RegAddrWidth = 4;

  // Opcode field, instr[15:12]
  typedef enum logic [3:0] {
    OpAdd    = 4'b0000,
    OpSub    = 4'b0001,
    OpRed    = 4'b0010,
    OpXor    = 4'b0011,
    OpSll    = 4'b0100,
    OpSra    = 4'b0101,
    OpRor    = 4'b0110,
    OpPaddsb = 4'b0111,
    OpLw     = 4'b1000,
    OpSw     = 4'b1001,
    OpLhb    = 4'b1010,
    OpLlb    = 4'b1011,
    OpB      = 4'b1100,
    OpBr     = 4'b1101,
    OpPcs    = 4'b1110,
    OpHlt    = 4'b1111
  } opcodeT;

  // Branch condition, instr[11:9]
  typedef enum logic [2:0] {
    CondNe     = 3'b000,
    CondEq     = 3'b001,
    CondGt     = 3'b010,
    CondLt     = 3'b011,
    CondGte    = 3'b100,
    CondLte    = 3'b101,
    CondOv     = 3'b110,
    CondUncond = 3'b111
  } condT;

  localparam int FlagN = 2;
  localparam int FlagV = 1;
  localparam int FlagZ = 0;

endpackage

`default_nettype wire

/* src/pcCounter.sv */
`timescale 1ns/100ps
`default_nettype none

module pcCounter (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         step,
  input  logic                         load,
  input  logic                         clear,
  input  logic [8:0]                   offset,
  output logic [isaPkg::DataWidth-1:0] pc
);
  import isaPkg::*;

  logic [DataWidth-1:0] pcPlus2;
  logic [DataWidth-1:0] branchDisp;

  assign pcPlus2 = pc + DataWidth'(2);

  // Word offset, sign extended and doubled into bytes
  assign branchDisp = {{(DataWidth-10){offset[8]}}, offset, 1'b0};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
    end else if (clear) begin
      pc <= '0;                       // Restart from address 0
    end else if (load) begin
      pc <= pcPlus2 + branchDisp;
    end else if (step) begin
      pc <= pcPlus2;
    end
  end

endmodule

`default_nettype wire

/* src/regFile.sv */
`timescale 1ns/100ps
`default_nettype none

module regFile (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic [isaPkg::RegAddrWidth-1:0] rdAddr1,
  input  logic [isaPkg::RegAddrWidth-1:0] rdAddr2,
  output logic [isaPkg::DataWidth-1:0]    rdData1,
  output logic [isaPkg::DataWidth-1:0]    rdData2,
  input  logic                            wrEn,
  input  logic [isaPkg::RegAddrWidth-1:0] wrAddr,
  input  logic [isaPkg::DataWidth-1:0]    wrData
);
  import isaPkg::*;

  localparam int NumRegs = 2 ** RegAddrWidth;

  // No storage behind register 0
  logic [DataWidth-1:0] regs [1:NumRegs-1];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;  // Writes to r0 fall away here
    end
  end

  assign rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];
  assign rdData2 = (rdAddr2 == '0) ? '0 : regs[rdAddr2];

endmodule

`default_nettype wire

/* tests/cpuTb.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuTb;
  import isaPkg::*;
  import busPkg::*;

  localparam int ImemDepth = 64;
  localparam int IdxWidth = $clog2(ImemDepth);

  typedef enum logic [1:0] {
    RowWrite,
    RowRead,
    RowHalt
  } rowOpT;

  typedef struct packed {
    rowOpT       op;
    logic [7:0]  addr;
    logic [15:0] data;      // Write data, or instruction count for RowHalt
    logic [15:0] expected;  // Read value, or the PC of the HLT for RowHalt
  } rowT;

  logic                    clk;
  logic                    rstN;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [ApbAddrWidth-1:0] paddr;
  logic [DataWidth-1:0]    pwdata;
  logic [DataWidth-1:0]    prdata;
  logic [DataWidth-1:0]    pc;
  logic                    hlt;

  int                   seed;
  int                   limitCycles;
  rowT                  stimRows[$];
  logic [DataWidth-1:0] prog[$];
  logic [DataWidth-1:0] modelMem [ImemDepth];
  logic [DataWidth-1:0] modelRegs [16];
  logic                 modelN;
  logic                 modelV;
  logic                 modelZ;

  cpuTop #(
    .ImemDepth(ImemDepth)
  ) i_cpuTop (
    .clk    (clk),
    .rstN   (rstN),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .paddr  (paddr),
    .pwdata (pwdata),
    .prdata (prdata),
    .pc     (pc),
    .hlt    (hlt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stopOnFailure(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic compareValue(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
    if (actual !== expected) begin
      stopOnFailure($sformatf("ERROR at %0t: %s is %h, expected %h",
                              $time, name, actual, expected));
    end
  endtask

  task automatic pushRow(input rowOpT op, input logic [7:0] addr,
                         input logic [15:0] data, input logic [15:0] expected);
    rowT row;
    row.op = op;
    row.addr = addr;
    row.data = data;
    row.expected = expected;
    stimRows.push_back(row);
  endtask

  function automatic logic [15:0] aluWord(input opcodeT op, input int rd,
                                          input int rs, input int rt);
    return {op, 4'(rd), 4'(rs), 4'(rt)};
  endfunction

  function automatic logic [15:0] immWord(input opcodeT op, input int rd,
                                          input logic [7:0] imm);
    return {op, 4'(rd), imm};
  endfunction

  // Offset counts words past the instruction after the branch
  function automatic logic [15:0] branchWord(input int cond, input logic [8:0] offset);
    return {OpB, 3'(cond), offset};
  endfunction

  function automatic logic conditionHolds(input logic [2:0] cond);
    case (cond)
      CondNe:  return !modelZ;
      CondEq:  return modelZ;
      CondGt:  return !modelZ && !modelN;
      CondLt:  return modelN;
      CondGte: return modelZ || !modelN;
      CondLte: return modelN || modelZ;
      CondOv:  return modelV;
      default: return 1'b1;
    endcase
  endfunction

  // Reference ISA model that runs from address 0 until HLT
  task automatic modelRun(output int count, output logic [15:0] endPc);
    logic [15:0] mpc;
    logic [15:0] nextPc;
    logic [15:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    logic        wb;
    logic        done;
    int          sum;
    mpc = '0;
    count = 0;
    done = 1'b0;
    {modelN, modelV, modelZ} = 3'b000;  // Start clears the flags
    while (!done) begin
      w = modelMem[mpc[IdxWidth:1]];
      a = modelRegs[w[7:4]];
      b = modelRegs[w[3:0]];
      res = '0;
      wb = 1'b0;
      nextPc = mpc + 16'd2;
      count++;
      case (w[15:12])
        OpAdd, OpSub: begin
          if (w[15:12] == OpSub) sum = int'($signed(a)) - int'($signed(b));
          else sum = int'($signed(a)) + int'($signed(b));
          modelV = (sum > 32767) || (sum < -32768);
          if (sum > 32767) res = 16'h7fff;
          else if (sum < -32768) res = 16'h8000;
          else res = sum[15:0];
          modelN = res[15];
          modelZ = (res == '0);
          wb = 1'b1;
        end
        OpXor: begin
          res = a ^ b;
          modelZ = (res == '0);  // N and V untouched
          wb = 1'b1;
        end
        OpLlb: begin
          res = {modelRegs[w[11:8]][15:8], w[7:0]};
          wb = 1'b1;
        end
        OpLhb: begin
          res = {w[7:0], modelRegs[w[11:8]][7:0]};
          wb = 1'b1;
        end
        OpB: if (conditionHolds(w[11:9])) nextPc = mpc + 16'd2 + {{6{w[8]}}, w[8:0], 1'b0};
        OpHlt: begin
          nextPc = mpc;
          done = 1'b1;
        end
        default: ;  // Dropped opcodes only advance the PC
      endcase
      if (wb && (w[11:8] != 4'd0)) modelRegs[w[11:8]] = res;
      mpc = nextPc;
      if (count > 1000) stopOnFailure("Reference model never reached HLT");
    end
    endPc = mpc;
  endtask

  task automatic loadValue(input int rd, input logic [15:0] value);
    prog.push_back(immWord(OpLlb, rd, value[7:0]));
    prog.push_back(immWord(OpLhb, rd, value[15:8]));
  endtask

  // Memory load, start, halt wait, then status, PC and register readback
  task automatic loadProgram();
    int          count;
    logic [15:0] endPc;
    foreach (prog[i]) begin
      modelMem[IdxWidth'(i)] = prog[i];
      pushRow(RowWrite, 8'h80 | 8'(i), prog[i], '0);
    end
    pushRow(RowWrite, CtrlAddr, 16'h0001, '0);
    modelRun(count, endPc);
    pushRow(RowHalt, '0, 16'(count), endPc);
    pushRow(RowRead, CtrlAddr, '0, 16'h0002);  // Halted and not busy
    pushRow(RowRead, PcAddr, '0, endPc);
    for (int r = 0; r < 16; r++) pushRow(RowRead, 8'h40 | 8'(r), '0, modelRegs[4'(r)]);
    prog.delete();
  endtask

  task automatic buildStimulus();
    int pairA [4];
    int pairB [4];
    int k;
    pairA = '{5, 5, 10, 1};
    pairB = '{6, 10, 5, 2};
    modelRegs = '{default: '0};
    pushRow(RowRead, CtrlAddr, '0, '0);
    pushRow(RowRead, PcAddr, '0, '0);
    for (int r = 0; r < 16; r++) pushRow(RowRead, 8'h40 | 8'(r), '0, '0);
    for (int r = 1; r <= 4; r++) loadValue(r, 16'($random(seed)));
    loadValue(5, 16'h7000);
    loadValue(6, 16'h7000);
    loadValue(10, 16'h9000);
    prog.push_back(aluWord(OpAdd, 7, 5, 6));   // Positive overflow
    prog.push_back(aluWord(OpSub, 9, 10, 5));  // Negative overflow
    prog.push_back(aluWord(OpAdd, 11, 1, 2));
    prog.push_back(aluWord(OpSub, 12, 3, 4));
    prog.push_back(aluWord(OpXor, 13, 1, 3));
    prog.push_back(aluWord(OpXor, 14, 2, 2));
    prog.push_back(aluWord(OpAdd, 8, 1, 0));
    prog.push_back(16'hf000);
    loadProgram();
    // Every condition twice against two different compares
    for (int p = 0; p < 2; p++) begin
      for (int c = 0; c < 8; c++) begin
        k = (c + 2 * p) % 4;
        prog.push_back(aluWord(OpSub, 0, pairA[2'(k)], pairB[2'(k)]));
        prog.push_back(branchWord(c, 9'd1));
        prog.push_back(immWord(OpLlb, 8 + c, 8'(16 * p + c + 1)));  // Marker
      end
    end
    prog.push_back(aluWord(OpLw, 3, 1, 2));
    prog.push_back(aluWord(OpSll, 4, 4, 4));
    prog.push_back(aluWord(OpPcs, 5, 0, 0));
    prog.push_back(aluWord(OpAdd, 0, 1, 2));
    prog.push_back(16'hf000);
    loadProgram();
  endtask

  task automatic busAccess(input logic write, input logic [7:0] addr,
                           input logic [15:0] data, input logic [15:0] expected);
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= write;
    paddr <= addr;
    pwdata <= data;
    @(posedge clk);
    penable <= 1'b1;
    if (!write) begin
      @(negedge clk);
      compareValue($sformatf("prdata[%h]", addr), prdata, expected);
    end
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
  endtask

  // First negedge lies half a cycle after the start edge
  task automatic waitForHalt(input int count, input logic [15:0] haltPc);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!hlt && (cycles < 2 * count + 1));
    compareValue("hlt", 16'(hlt), 16'h0001);
    compareValue("haltCycles", 16'(cycles), 16'(2 * count + 1));
    compareValue("pc", pc, haltPc);
  endtask

  initial begin
    int budget;
    seed = 32'h0fe36ffa;
    rstN = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    buildStimulus();
    budget = 4 + 100;
    foreach (stimRows[i]) begin
      budget += (stimRows[i].op == RowHalt) ? 2 * int'(stimRows[i].data) + 2 : 3;
    end
    limitCycles = budget;
    repeat (4) @(posedge clk);
    rstN <= 1'b1;
    foreach (stimRows[i]) begin
      case (stimRows[i].op)
        RowWrite: busAccess(1'b1, stimRows[i].addr, stimRows[i].data, '0);
        RowRead:  busAccess(1'b0, stimRows[i].addr, '0, stimRows[i].expected);
        default:  waitForHalt(int'(stimRows[i].data), stimRows[i].expected);
      endcase
    end
    $display("sim passed");
    $finish;
  end

  initial begin
    wait (limitCycles > 0);
    repeat (limitCycles) @(posedge clk);
    stopOnFailure($sformatf("Watchdog expired after %0d cycles, the DUT appears to hang",
                            limitCycles));
  end

endmodule

`default_nettype wire

/* tests/cpuTop_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuTopProperties (
  input logic                         clk,
  input logic                         rstN,
  input logic                         psel,
  input logic                         penable,
  input logic                         pwrite,
  input logic [isaPkg::DataWidth-1:0] prdata,
  input logic [isaPkg::DataWidth-1:0] pc,
  input logic                         hlt
);

  // Core comes out of reset running nothing
  hltLowAfterReset: assert property (
    @(posedge clk) $rose(rstN) |=> !hlt
  ) else $error("hlt is high one cycle after reset");

  // A halted core keeps its PC on the HLT
  pcHeldWhileHalted: assert property (
    @(posedge clk) disable iff (!rstN)
    hlt |-> $stable(pc)
  ) else $error("pc moved while hlt is high");

  prdataIdleZero: assert property (
    @(posedge clk) disable iff (!rstN)
    !(psel && penable && !pwrite) |-> (prdata == '0)
  ) else $error("prdata is not zero outside a read access phase");

endmodule

bind cpuTop cpuTopProperties i_cpuTopProperties (
  .clk    (clk),
  .rstN   (rstN),
  .psel   (psel),
  .penable(penable),
  .pwrite (pwrite),
  .prdata (prdata),
  .pc     (pc),
  .hlt    (hlt)
);

`default_nettype wire
